// ==== Makefile ====
# Verilator build and run of the flow arbiter testbench

VERILATOR ?= verilator
TOP       ?= br_flow_arb_mux_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Regression failed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh tb/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log is searched for the fail message, a crash fails through the exit status
run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
+incdir+src
src/br_flow_pkg.sv
src/br_rr_select.sv
src/br_flow_mux_select.sv
src/br_flow_reg_fwd.sv
src/br_flow_arb_mux.sv
tb/br_flow_arb_mux_tb.sv

// ==== src/br_flow_arb_mux.sv ====
`timescale 1ns/1ps

`include "br_flow_defs.svh"

// Ready-valid flow arbiter
// Round-robin select, select mux, then a forward register that
// tags each word with the flow it came from
module br_flow_arb_mux (
  input  logic                      clk,
  input  logic                      rst,

  // Producer flows
  input  logic [`BR_NUM_FLOWS-1:0]  push_valid,
  output logic [`BR_NUM_FLOWS-1:0]  push_ready,
  input  br_flow_pkg::data_t        push_data [`BR_NUM_FLOWS],

  // Consumer side
  input  logic                      pop_ready,
  output logic                      pop_valid,
  output br_flow_pkg::data_t        pop_data,
  output br_flow_pkg::flow_id_t     pop_flow
);

  import br_flow_pkg::*;

  localparam int NumFlows = `BR_NUM_FLOWS;

  // ------------------------------------------------------------
  // Internal nets
  // ------------------------------------------------------------

  // Granted flow, registered inside the select generator
  flow_id_t select;

  // Mux to register handshake
  logic     mux_valid;
  logic     mux_ready;
  data_t    mux_data;

  // Tagged word into and out of the register
  tagged_t  mux_item;
  tagged_t  pop_item;

  // ------------------------------------------------------------
  // Select generator
  // ------------------------------------------------------------

  // Watches the mux's ready so a stalled grant stays put
  br_rr_select #(
    .NumFlows(NumFlows)
  ) u_rr_select (
    .clk       (clk),
    .rst       (rst),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .select    (select)
  );

  // ------------------------------------------------------------
  // Select mux
  // ------------------------------------------------------------

  br_flow_mux_select #(
    .NumFlows (NumFlows),
    .payload_t(data_t)
  ) u_mux (
    .select    (select),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_data (push_data),
    .pop_ready (mux_ready),
    .pop_valid (mux_valid),
    .pop_data  (mux_data)
  );

  // Tag with the grant, it matches the flow behind mux_data
  assign mux_item = '{flow: select, data: mux_data};

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------

  br_flow_reg_fwd #(
    .payload_t(tagged_t)
  ) u_reg (
    .clk       (clk),
    .rst       (rst),
    .push_valid(mux_valid),
    .push_ready(mux_ready),
    .push_data (mux_item),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_data  (pop_item)
  );

  // Split the held item back into its fields
  assign pop_flow = pop_item.flow;
  assign pop_data = pop_item.data;

endmodule : br_flow_arb_mux

// ==== src/br_flow_defs.svh ====
`ifndef BR_FLOW_DEFS_SVH
`define BR_FLOW_DEFS_SVH

// ------------------------------------------------------------
// Flow arbiter sizing
// ------------------------------------------------------------

// Number of producer flows feeding the arbiter
`define BR_NUM_FLOWS 4

// Bits per data word on every flow
`define BR_DATA_WIDTH 16

// Flow id width is derived in the package from BR_NUM_FLOWS

`endif

// ==== src/br_flow_mux_select.sv ====
`timescale 1ns/1ps

`include "br_flow_defs.svh"

// Ready-valid mux with an explicit binary select
// Purely combinational, zero cycles from push to pop
// Pop side is stable as long as select holds under backpressure
module br_flow_mux_select #(
  // At least 1
  parameter int NumFlows = `BR_NUM_FLOWS,
  // Word carried by each flow
  parameter type payload_t = br_flow_pkg::data_t,
  localparam int SelectWidth = br_flow_pkg::clamped_clog2(NumFlows)
) (
  // Index of the flow routed to the pop side, kept below NumFlows
  input  logic [SelectWidth-1:0] select,

  // Producer side
  input  logic [NumFlows-1:0]    push_valid,
  output logic [NumFlows-1:0]    push_ready,
  input  payload_t               push_data [NumFlows],

  // Consumer side
  input  logic                   pop_ready,
  output logic                   pop_valid,
  output payload_t               pop_data
);

  // ------------------------------------------------------------
  // Routing
  // ------------------------------------------------------------

  if (NumFlows == 1) begin : gen_single_flow

    // Only one flow, select carries no information
    assign push_ready = pop_ready;
    assign pop_valid  = push_valid[0];
    assign pop_data   = push_data[0];

  end else begin : gen_multi_flow

    // Consumer ready lands on the selected bit only
    // All other flows see 0 and stall
    assign push_ready = NumFlows'(pop_ready) << select;

    // Forward the selected offer
    assign pop_valid = push_valid[select];
    assign pop_data  = push_data[select];

  end

  // A transfer on the pop side is always a transfer on flow select,
  // since pop_valid and the selected push_ready are the same
  // signals as the selected push_valid and pop_ready

endmodule : br_flow_mux_select

// ==== src/br_flow_pkg.sv ====
`include "br_flow_defs.svh"

package br_flow_pkg;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  // Ceiling of log2, never below 1 bit
  function automatic int clamped_clog2(input int value);
    return (value > 1) ? $clog2(value) : 1;
  endfunction

  // Bits needed to name one flow
  localparam int FlowIdWidth = clamped_clog2(`BR_NUM_FLOWS);

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------

  // One data word from a producer
  typedef logic [`BR_DATA_WIDTH-1:0] data_t;

  // Flow number, also used as the mux select
  typedef logic [FlowIdWidth-1:0] flow_id_t;

  // Word tagged with its source flow, flow id in the upper bits
  typedef struct packed {
    flow_id_t flow;
    data_t    data;
  } tagged_t;

endpackage

// ==== src/br_flow_reg_fwd.sv ====
`timescale 1ns/1ps

// One-entry forward pipeline register
// Breaks the combinational valid and data path between two stages
// Ready still passes through combinationally, so throughput stays at
// one item per cycle
module br_flow_reg_fwd #(
  // Item held by the stage
  parameter type payload_t = br_flow_pkg::tagged_t
) (
  input  logic     clk,
  input  logic     rst,

  // Upstream side
  input  logic     push_valid,
  output logic     push_ready,
  input  payload_t push_data,

  // Downstream side, driven straight from the registers
  output logic     pop_valid,
  input  logic     pop_ready,
  output payload_t pop_data
);

  // ------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------

  // Space is available when empty or when the held item leaves now
  // New item can enter on the same edge the old one is popped
  assign push_ready = !pop_valid || pop_ready;

  logic push_xfer;

  // Word accepted on this edge
  assign push_xfer = push_valid && push_ready;

  // ------------------------------------------------------------
  // Valid bit
  // ------------------------------------------------------------

  // Reloaded whenever the slot frees up
  // Holds while the consumer stalls a full slot
  always_ff @(posedge clk) begin
    if (rst) begin
      pop_valid <= 1'b0;
    end else if (push_ready) begin
      pop_valid <= push_valid;
    end
  end

  // ------------------------------------------------------------
  // Payload
  // ------------------------------------------------------------

  // Captured only on an accepted word
  // Unchanged while stalled, so pop_data is stable under backpressure
  always_ff @(posedge clk) begin
    if (push_xfer) begin
      pop_data <= push_data;
    end
  end

  // Latency from push to pop is one cycle,
  // longer only while pop_ready is held low

endmodule : br_flow_reg_fwd

// ==== src/br_rr_select.sv ====
`timescale 1ns/1ps

`include "br_flow_defs.svh"

// Round-robin select generator for the flow mux
// Select is registered and only moves at a clock edge
// Choice is held while the chosen flow waits on backpressure
module br_rr_select #(
  // At least 1
  parameter int NumFlows = `BR_NUM_FLOWS,
  localparam int SelectWidth = br_flow_pkg::clamped_clog2(NumFlows)
) (
  input  logic                   clk,
  input  logic                   rst,
  // Offers from every producer
  input  logic [NumFlows-1:0]    push_valid,
  // Ready as returned by the mux, only the selected bit can be set
  input  logic [NumFlows-1:0]    push_ready,
  // Binary index of the granted flow
  output logic [SelectWidth-1:0] select
);

  // ------------------------------------------------------------
  // State
  // ------------------------------------------------------------

  // Priority pointer, first flow to consider on the next search
  logic [SelectWidth-1:0] ptr_q;
  logic [SelectWidth-1:0] ptr_d;

  // Current grant
  logic [SelectWidth-1:0] select_q;
  logic [SelectWidth-1:0] select_d;

  // Status of the granted flow this cycle
  logic sel_valid;
  logic sel_ready;
  logic locked;
  logic transfer;

  // Result of the round-robin search
  logic                   found;
  logic [SelectWidth-1:0] next_flow;

  // ------------------------------------------------------------
  // Granted flow status
  // ------------------------------------------------------------

  assign sel_valid = push_valid[select_q];
  assign sel_ready = push_ready[select_q];

  // Offered but stalled, keep pointing at it so the pop side stays stable
  assign locked = sel_valid && !sel_ready;

  // Word leaves the granted flow on this edge
  assign transfer = sel_valid && sel_ready;

  // ------------------------------------------------------------
  // Pointer update
  // ------------------------------------------------------------

  // Move one past the flow that just transferred, wrapping at the top
  always_comb begin
    ptr_d = ptr_q;
    if (transfer) begin
      if (select_q == SelectWidth'(NumFlows - 1)) begin
        ptr_d = '0;
      end else begin
        ptr_d = select_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Round-robin search
  // ------------------------------------------------------------

  // First valid flow at or after the updated pointer
  // With nothing valid the grant rests on the pointer
  always_comb begin
    int idx;
    found     = 1'b0;
    next_flow = ptr_d;
    for (int i = 0; i < NumFlows; i++) begin
      idx = (int'(ptr_d) + i) % NumFlows;
      if (!found && push_valid[idx]) begin
        found     = 1'b1;
        next_flow = SelectWidth'(idx);
      end
    end
  end

  // Hold while locked, otherwise take the search result
  assign select_d = locked ? select_q : next_flow;

  // ------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q    <= '0;
      select_q <= '0;
    end else begin
      ptr_q    <= ptr_d;
      select_q <= select_d;
    end
  end

  assign select = select_q;

endmodule : br_rr_select

// ==== tb/br_flow_arb_mux_tb.sv ====
`timescale 1ns/1ps

`include "br_flow_defs.svh"

module br_flow_arb_mux_tb;

  import br_flow_pkg::*;

  // ------------------------------------------------------------
  // Run parameters
  // ------------------------------------------------------------

  localparam int num_flows      = `BR_NUM_FLOWS;
  localparam int words_per_flow = 120;
  localparam int total_words    = words_per_flow * num_flows;
  // Words taken with every flow valid and the consumer always ready
  localparam int sat_words      = 40;
  // Four cycles per word plus slack for reset and drain
  localparam int cycle_limit    = total_words * 4 + 200;
  // Chance in percent that an idle producer offers a word
  localparam int valid_pct      = 45;
  localparam int ready_pct      = 70;

  // ------------------------------------------------------------
  // DUT signals
  // ------------------------------------------------------------

  logic                 clk;
  logic                 rst;
  logic [num_flows-1:0] push_valid;
  logic [num_flows-1:0] push_ready;
  data_t                push_data [num_flows];
  logic                 pop_ready;
  logic                 pop_valid;
  data_t                pop_data;
  flow_id_t             pop_flow;

  // ------------------------------------------------------------
  // Model and bookkeeping
  // ------------------------------------------------------------

  // Arbiter state as the rules predict it
  int                   model_ptr;
  int                   model_sel;
  logic                 model_reg_valid;
  // Words in flight in push order
  tagged_t              exp_q [$];

  // Producer side
  logic [num_flows-1:0] accepted;
  int                   words_left [num_flows];
  int                   gen_count [num_flows];
  int                   pop_count [num_flows];

  // Saturated phase at the start of the run
  bit                   saturate;
  int                   rr_next;
  int                   sat_cycles;
  int                   total_accepted;

  // Output state of the previous cycle for the stall and latency checks
  bit                   stalled_prev;
  bit                   pushed_prev;
  data_t                held_data;
  flow_id_t             held_flow;

  int                   value_errors;
  int                   other_errors;
  int                   cycle;
  bit                   drained;

  br_flow_arb_mux UUT (
    .clk       (clk),
    .rst       (rst),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_data (push_data),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .pop_flow  (pop_flow)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Reporting
  // ------------------------------------------------------------

  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    value_errors++;
    $display("Error at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
  endtask

  task automatic report_failure(string what);
    other_errors++;
    $display("Failure at time %0t: %s", $time, what);
  endtask

  // ------------------------------------------------------------
  // Stimulus, applied on the falling edge
  // ------------------------------------------------------------

  task automatic drive_inputs();
    for (int k = 0; k < num_flows; k++) begin
      // Producer drops valid once its word went out on the last edge
      if (accepted[k]) begin
        push_valid[k] = 1'b0;
      end
      // Idle producer may offer a fresh word
      if (!push_valid[k] && words_left[k] > 0) begin
        if (saturate || ($urandom % 100) < valid_pct) begin
          push_valid[k] = 1'b1;
          push_data[k]  = data_t'($urandom);
          words_left[k]--;
          gen_count[k]++;
        end
      end
    end
    pop_ready = saturate ? 1'b1 : (($urandom % 100) < ready_pct);
  endtask

  // Nothing left to send and nothing in flight
  function automatic bit all_drained();
    bit done;
    done = (push_valid == '0) && !model_reg_valid && (exp_q.size() == 0);
    for (int k = 0; k < num_flows; k++) begin
      if (words_left[k] != 0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  // ------------------------------------------------------------
  // Per-cycle checks and model step
  // ------------------------------------------------------------

  task automatic check_cycle();
    logic [num_flows-1:0] exp_ready;
    logic [num_flows-1:0] rr_grant;
    logic                 mux_ready_m;
    logic                 sel_valid;
    logic                 push_xfer;
    logic                 pop_xfer;
    tagged_t              item;
    int                   ptr_next;
    int                   sel_next;
    int                   idx;
    bit                   found;

    // Register takes a word when empty or draining now
    mux_ready_m = !model_reg_valid || pop_ready;
    exp_ready   = '0;
    if (mux_ready_m) begin
      exp_ready[model_sel] = 1'b1;
    end
    sel_valid = push_valid[model_sel];
    push_xfer = sel_valid && mux_ready_m;
    pop_xfer  = pop_valid && pop_ready;

    assert (push_ready === exp_ready)
      else report_mismatch("push_ready", 32'(exp_ready), 32'(push_ready));
    assert (pop_valid === model_reg_valid)
      else report_mismatch("pop_valid", 32'(model_reg_valid), 32'(pop_valid));

    // Stalled word stays put
    if (stalled_prev) begin
      assert (pop_valid === 1'b1)
        else report_mismatch("pop_valid", 32'(1), 32'(pop_valid));
      assert (pop_data === held_data)
        else report_mismatch("pop_data", 32'(held_data), 32'(pop_data));
      assert (pop_flow === held_flow)
        else report_mismatch("pop_flow", 32'(held_flow), 32'(pop_flow));
    end

    // One cycle of latency
    if (pushed_prev) begin
      assert (pop_valid === 1'b1)
        else report_failure("word accepted on the previous edge is not offered at the output");
    end

    // Every word the DUT hands out must be the oldest one in flight
    if (pop_xfer) begin
      pop_count[pop_flow]++;
      assert (exp_q.size() > 0) else report_failure("word popped while none was expected");
      if (exp_q.size() > 0) begin
        item = exp_q.pop_front();
        assert (pop_flow === item.flow)
          else report_mismatch("pop_flow", 32'(item.flow), 32'(pop_flow));
        assert (pop_data === item.data)
          else report_mismatch("pop_data", 32'(item.data), 32'(pop_data));
      end
    end

    // Producers see the handshake on the DUT ports
    accepted = push_valid & push_ready;
    if (push_xfer) begin
      item.flow = flow_id_t'(model_sel);
      item.data = push_data[model_sel];
      exp_q.push_back(item);
      total_accepted++;
    end

    // All flows busy and the consumer ready give strict rotation at full rate
    if (saturate) begin
      rr_grant          = '0;
      rr_grant[rr_next] = 1'b1;
      assert (push_ready === rr_grant)
        else report_mismatch("push_ready", 32'(rr_grant), 32'(push_ready));
      rr_next = (rr_next + 1) % num_flows;
      if (sat_cycles > 0) begin
        assert (pop_xfer) else report_failure("no word popped during the saturated phase");
      end
      sat_cycles++;
    end

    // Register model
    if (mux_ready_m) begin
      model_reg_valid = sel_valid;
    end

    // Priority moves past the flow that just sent
    ptr_next = push_xfer ? (model_sel + 1) % num_flows : model_ptr;

    // Grant holds while the granted flow is stalled
    // Otherwise the next valid flow from the pointer
    sel_next = ptr_next;
    if (sel_valid && !mux_ready_m) begin
      sel_next = model_sel;
    end else begin
      found = 1'b0;
      for (int i = 0; i < num_flows; i++) begin
        idx = (ptr_next + i) % num_flows;
        if (!found && push_valid[idx]) begin
          found    = 1'b1;
          sel_next = idx;
        end
      end
    end
    model_ptr = ptr_next;
    model_sel = sel_next;

    stalled_prev = pop_valid && !pop_ready;
    held_data    = pop_data;
    held_flow    = pop_flow;
    pushed_prev  = push_xfer;
    saturate     = (total_accepted < sat_words);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    rst        = 1'b1;
    pop_ready  = 1'b0;
    push_valid = '0;
    for (int k = 0; k < num_flows; k++) begin
      push_data[k]  = '0;
      words_left[k] = words_per_flow;
      gen_count[k]  = 0;
      pop_count[k]  = 0;
    end
    model_ptr       = 0;
    model_sel       = 0;
    model_reg_valid = 1'b0;
    accepted        = '0;
    saturate        = 1'b1;
    rr_next         = 0;
    sat_cycles      = 0;
    total_accepted  = 0;
    stalled_prev    = 1'b0;
    pushed_prev     = 1'b0;
    value_errors    = 0;
    other_errors    = 0;
    cycle           = 0;
    drained         = 1'b0;
    void'($urandom(32'h8c1d_8519));

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;

    // Output empty and grant parked on flow 0
    assert (pop_valid === 1'b0) else report_mismatch("pop_valid", 32'(0), 32'(pop_valid));
    assert (push_ready === num_flows'(1))
      else report_mismatch("push_ready", 32'(1), 32'(push_ready));

    while (!drained && cycle < cycle_limit) begin
      @(negedge clk);
      drive_inputs();
      #1;
      if (all_drained()) begin
        drained = 1'b1;
      end else begin
        check_cycle();
        cycle++;
      end
    end

    assert (drained)
      else report_failure($sformatf("run hit the limit of %0d cycles before draining",
                                    cycle_limit));
    for (int k = 0; k < num_flows; k++) begin
      assert (pop_count[k] == gen_count[k])
        else report_failure($sformatf("flow %0d popped %0d of %0d words", k, pop_count[k],
                                      gen_count[k]));
    end
    assert (exp_q.size() == 0)
      else report_failure($sformatf("%0d expected words never came out", exp_q.size()));

    $display("Summary: %0d value errors, %0d other errors, %0d cycles", value_errors,
             other_errors, cycle);
    if (value_errors + other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : br_flow_arb_mux_tb
